// File: dataCache.f
cachePkg.sv
memBusPkg.sv
loadStoreAlign.sv
cacheStore.sv
cacheCtrl.sv
memWaitTimer.sv
mainMemory.sv
dataCacheTop.sv
dataCacheTb.sv

// File: Makefile
SIM = obj_dir/VdataCacheTb

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

$(SIM): dataCache.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module dataCacheTb -f dataCache.f

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -Wall \
		--top-module dataCacheTop -f dataCache.f

clean:
	rm -rf obj_dir sim.log

// File: dataCacheTb.sv
module dataCacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cachePkg::*;
    import memBusPkg::*;

    localparam int NumRandom    = 400;
    localparam int NumDirected  = 10;
    localparam int WorstLatency = 2 * (MemLatency + 1) + 4;   // Dirty miss plus replay
    localparam int StallSlack   = 8;                          // Back-pressure and idle gaps
    localparam int CycleLimit   = 2 * (NumRandom + NumDirected) * (WorstLatency + StallSlack);

    logic    clk      = 1'b0;
    logic    rst      = 1'b1;
    logic    reqValid = 1'b0;
    cpuReq_t req      = '0;
    logic    rspReady = 1'b0;
    logic    reqReady;
    logic    rspValid;
    cpuRsp_t rsp;

    integer  seed       = 32'h4957_78de;
    int      errors     = 0;
    int      checks     = 0;
    int      cycleCount = 0;

    // Reference memory and cache tags
    word_t   modelMem   [MemWords]         = '{default: '0};
    tag_t    modelTag   [NumSets][NumWays] = '{default: '0};
    logic    modelValid [NumSets][NumWays] = '{default: 1'b0};
    way_t    modelLru   [NumSets]          = '{default: '0};   // Next way to replace

    dataCacheTop dut_i (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .rspValid(rspValid), .rspReady(rspReady), .rsp(rsp)
    );

    always #4 clk = ~clk;

    // Stops a stuck run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("ERROR: run did not finish within %0d cycles", CycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;   // Inputs change away from the edge
    endtask

    // Lane select and extension of a load
    function automatic word_t extendLoad(accessSize_e size, logic [1:0] offset, word_t w);
        word_t lanes;
        lanes = w >> (8 * offset);   // Addressed byte now at bit 0
        case (size)
            LB:      return {{24{lanes[7]}}, lanes[7:0]};
            LH:      return {{16{lanes[15]}}, lanes[15:0]};
            LBU:     return {24'b0, lanes[7:0]};
            LHU:     return {16'b0, lanes[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic word_t mergeStore(accessSize_e size, logic [1:0] offset, word_t old,
                                         word_t data);
        word_t mask;
        case (size)
            LB:      mask = 32'h0000_00FF;
            LH:      mask = 32'h0000_FFFF;
            default: mask = 32'hFFFF_FFFF;
        endcase
        mask = mask << (8 * offset);
        return (old & ~mask) | ((data << (8 * offset)) & mask);
    endfunction

    // Tag lookup, a miss allocates the LRU way
    task automatic modelLookup(input addr_t addr, output logic found);
        index_t idx;
        way_t   way;
        idx   = addr[3:2];
        way   = modelLru[idx];
        found = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            if (modelValid[idx][w] && (modelTag[idx][w] == addr[31:4])) begin
                found = 1'b1;
                way   = way_t'(w);
            end
        end
        modelTag[idx][way]   = addr[31:4];
        modelValid[idx][way] = 1'b1;
        modelLru[idx]        = ~way;   // Other way is older now
    endtask

    task automatic predict(input cpuReq_t r, output word_t data, output logic hitFlag);
        int idx;
        idx  = r.addr[9:2];
        data = '0;   // Stores answer with zero
        if (r.addr[31:2] == MmioAddr[31:2]) begin
            hitFlag = 1'b0;   // Whole word straight to memory
            if (r.write)
                modelMem[idx] = r.wdata;
            else
                data = modelMem[idx];
        end else begin
            modelLookup(r.addr, hitFlag);
            if (r.write)
                modelMem[idx] = mergeStore(r.size, r.addr[1:0], modelMem[idx], r.wdata);
            else
                data = extendLoad(r.size, r.addr[1:0], modelMem[idx]);
        end
    endtask

    task automatic randomReq(output cpuReq_t r);
        int unsigned pick;
        int unsigned wordNum;
        logic [1:0]  offset;
        pick    = $unsigned($random(seed)) % 100;
        wordNum = $unsigned($random(seed)) % MemWords;   // Whole 1 KB
        if (pick < 60)
            wordNum = wordNum % 12;   // Three tags per set
        offset  = 2'($random(seed));
        r.write = ($unsigned($random(seed)) % 10) < 4;
        r.wdata = $random(seed);
        case ($unsigned($random(seed)) % (r.write ? 3 : 5))
            0:       r.size = LB;
            1:       r.size = LH;
            2:       r.size = LW;
            3:       r.size = LBU;
            default: r.size = LHU;
        endcase
        if (pick >= 95) begin
            wordNum = MmioAddr[9:2];
            r.size  = LW;
        end
        if (r.size == LW)
            offset = 2'b00;
        else if ((r.size == LH) || (r.size == LHU))
            offset[0] = 1'b0;   // Halfword aligned
        r.addr = {22'b0, wordNum[7:0], offset};
    endtask

    // One full request and response, with random back-pressure
    task automatic doAccess(input string name, input cpuReq_t r);
        word_t   expData;
        logic    expHit;
        cpuRsp_t firstRsp;
        logic    seen;
        logic    taken;
        int      latency;
        predict(r, expData, expHit);
        reqValid = 1'b1;
        req      = r;
        while (!reqReady)
            nextCycle();
        nextCycle();   // Accepted on this edge
        reqValid  = 1'b0;
        req.addr  = $random(seed);   // DUT must hold its own copy
        req.wdata = $random(seed);
        seen    = 1'b0;
        taken   = 1'b0;
        latency = 0;
        while (!taken) begin
            rspReady = ($unsigned($random(seed)) % 4) != 0;   // Low a quarter of the time
            checkValue({name, " reqReady busy"}, 0, reqReady);
            if (rspValid) begin
                if (!seen) begin
                    firstRsp = rsp;
                    seen     = 1'b1;
                    if (expHit)
                        checkValue({name, " hit latency"}, 1, latency);
                end
                checkValue({name, " rsp stable"}, firstRsp, rsp);
                taken = rspReady;
            end
            nextCycle();
            latency++;
        end
        checkValue({name, " single rsp"}, 0, rspValid);
        checkValue({name, " rdata"}, expData, firstRsp.rdata);
        checkValue({name, " hit"}, expHit, firstRsp.hit);
    endtask

    initial begin
        cpuReq_t r;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("reset reqReady", 1, reqReady);
        checkValue("reset rspValid", 0, rspValid);

        // Set 0 with three tags, dirty victims evicted and reloaded
        doAccess("sw fill tag 0", cpuReq_t'{1'b1, LW, 32'h0000_0000, 32'hA5C3_0F81});
        doAccess("lw hit tag 0", cpuReq_t'{1'b0, LW, 32'h0000_0000, 32'h0});
        doAccess("sb fill tag 1", cpuReq_t'{1'b1, LB, 32'h0000_0013, 32'h1234_569E});
        doAccess("lb hit tag 1", cpuReq_t'{1'b0, LB, 32'h0000_0013, 32'h0});
        doAccess("lw evict tag 0", cpuReq_t'{1'b0, LW, 32'h0000_0020, 32'h0});
        doAccess("lhu reload tag 0", cpuReq_t'{1'b0, LHU, 32'h0000_0002, 32'h0});
        doAccess("lb reload tag 1", cpuReq_t'{1'b0, LB, 32'h0000_0013, 32'h0});
        doAccess("sw mmio", cpuReq_t'{1'b1, LW, MmioAddr, 32'h7E11_0042});
        doAccess("lw mmio", cpuReq_t'{1'b0, LW, MmioAddr, 32'h0});
        doAccess("lh hit after mmio", cpuReq_t'{1'b0, LH, 32'h0000_0000, 32'h0});

        for (int n = 0; n < NumRandom; n++) begin
            randomReq(r);
            doAccess($sformatf("random %0d", n), r);
            repeat ($unsigned($random(seed)) % 3) begin
                nextCycle();
                checkValue("idle rspValid", 0, rspValid);   // Nothing in flight
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: dataCacheTop.sv
module dataCacheTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               reqValid,
    output logic               reqReady,
    input  memBusPkg::cpuReq_t req,
    output logic               rspValid,
    input  logic               rspReady,
    output memBusPkg::cpuRsp_t rsp
);
    import cachePkg::*;
    import memBusPkg::*;

    cpuReq_t curReq;

    // Store side
    logic  hit;
    word_t hitData;
    logic  victimDirty;
    tag_t  victimTag;
    word_t victimData;
    logic  fillEn;
    logic  writeEn;
    logic  lruTouch;

    // Alignment
    word_t mergedWord;
    word_t loadData;

    // Memory side
    memReq_t memReq;
    logic    memStart;
    logic    memDone;
    word_t   memRdata;

    cacheCtrl ctrl_i (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqReady(reqReady), .req(req),
        .rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
        .hit(hit), .victimDirty(victimDirty),
        .victimTag(victimTag), .victimData(victimData),
        .loadData(loadData), .memRdata(memRdata), .memDone(memDone),
        .memReq(memReq), .memStart(memStart), .curReq(curReq),
        .fillEn(fillEn), .writeEn(writeEn), .lruTouch(lruTouch)
    );

    cacheStore store_i (
        .clk(clk), .rst(rst),
        .index(curReq.addr[3:2]), .tag(curReq.addr[31:4]),
        .fillEn(fillEn), .writeEn(writeEn), .lruTouch(lruTouch),
        .fillData(memRdata), .writeData(mergedWord),
        .hit(hit), .hitWay(), .hitData(hitData),   // Way only used inside the store
        .victimDirty(victimDirty), .victimTag(victimTag), .victimData(victimData)
    );

    loadStoreAlign align_i (
        .size(curReq.size), .byteOffset(curReq.addr[1:0]),
        .lineWord(hitData), .storeData(curReq.wdata),
        .mergedWord(mergedWord), .loadData(loadData)
    );

    memWaitTimer timer_i (
        .clk(clk), .rst(rst),
        .start(memStart), .done(memDone)
    );

    mainMemory mem_i (
        .clk(clk), .rst(rst),
        .req(memReq), .commit(memDone), .rdata(memRdata)
    );

endmodule

// File: mainMemory.sv
module mainMemory (
    input  logic               clk,
    input  logic               rst,
    input  memBusPkg::memReq_t req,
    input  logic               commit,   // Access completes this cycle
    output cachePkg::word_t    rdata
);
    import cachePkg::*;

    word_t ram [MemWords];

    // Cleared at reset to start from a known image
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                ram[i] <= '0;
            end
            rdata <= '0;
        end else if (commit) begin
            if (req.write) begin
                ram[req.wordAddr] <= req.wdata;
            end else begin
                rdata <= ram[req.wordAddr];   // Held until the next read
            end
        end
    end

endmodule

// File: memWaitTimer.sv
module memWaitTimer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);
    import cachePkg::*;

    typedef logic [$clog2(MemLatency + 1)-1:0] count_t;

    count_t cnt;    // Cycles left
    logic   busy;

    assign busy = (cnt != '0);
    assign done = (cnt == count_t'(1));   // Last cycle of the access

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= count_t'(MemLatency);   // Restarts even when busy
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// File: cacheCtrl.sv
module cacheCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               reqValid,
    output logic               reqReady,
    input  memBusPkg::cpuReq_t req,
    output logic               rspValid,
    input  logic               rspReady,
    output memBusPkg::cpuRsp_t rsp,
    input  logic               hit,
    input  logic               victimDirty,
    input  cachePkg::tag_t     victimTag,
    input  cachePkg::word_t    victimData,
    input  cachePkg::word_t    loadData,
    input  cachePkg::word_t    memRdata,
    input  logic               memDone,
    output memBusPkg::memReq_t memReq,
    output logic               memStart,
    output memBusPkg::cpuReq_t curReq,      // Drives the lookup
    output logic               fillEn,
    output logic               writeEn,
    output logic               lruTouch
);
    import cachePkg::*;
    import memBusPkg::*;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEBACK, FETCH, FILL, MMIO, RESPOND
    } ctrlState_e;

    ctrlState_e state;
    ctrlState_e nextState;

    logic  isMmio;      // Current request targets the MMIO word
    logic  lookupHit;   // Cached access served this cycle
    logic  missed;      // Access went through a fill
    logic  memDoneQ;    // Memory finished last cycle
    word_t rspData;
    logic  rspHit;

    assign isMmio    = (curReq.addr[31:2] == MmioAddr[31:2]);
    assign lookupHit = (state == LOOKUP) && !isMmio && hit;

    always_comb begin
        nextState = state;
        case (state)
            IDLE:      if (reqValid) nextState = LOOKUP;
            LOOKUP: begin
                if (isMmio)           nextState = MMIO;
                else if (hit)         nextState = RESPOND;
                else if (victimDirty) nextState = WRITEBACK;
                else                  nextState = FETCH;
            end
            WRITEBACK: if (memDone) nextState = FETCH;
            FETCH:     if (memDone) nextState = FILL;
            FILL:      nextState = LOOKUP;          // Replay, now a hit
            MMIO:      if (memDoneQ) nextState = RESPOND;   // Read word is registered
            RESPOND:   if (rspReady) nextState = IDLE;
            default:   nextState = IDLE;
        endcase
    end

    assign reqReady = (state == IDLE);
    assign rspValid = (state == RESPOND);
    assign rsp      = '{rdata: rspData, hit: rspHit};

    assign writeEn  = lookupHit && curReq.write;
    assign lruTouch = lookupHit && !curReq.write;
    assign fillEn   = (state == FILL);

    // Miss or MMIO starts memory from LOOKUP
    // Fetch after a writeback starts one cycle after its done
    assign memStart = ((state == LOOKUP) && (isMmio || !hit))
                   || ((state == FETCH) && memDoneQ);

    // Memory only samples this on done
    always_comb begin
        memReq.write    = 1'b0;
        memReq.wordAddr = memAddr_t'(curReq.addr >> 2);
        memReq.wdata    = '0;
        case (state)
            WRITEBACK: begin
                memReq.write    = 1'b1;
                memReq.wordAddr = memAddr_t'({victimTag, curReq.addr[3:2]});  // Victim's home
                memReq.wdata    = victimData;
            end
            MMIO: begin
                memReq.write = curReq.write;
                memReq.wdata = curReq.wdata;   // Full word
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            missed   <= 1'b0;
            memDoneQ <= 1'b0;
        end else begin
            state    <= nextState;
            memDoneQ <= memDone;
            if (state == IDLE) begin
                missed <= 1'b0;
            end else if ((state == LOOKUP) && !isMmio && !hit) begin
                missed <= 1'b1;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            curReq <= req;
        end
        if (lookupHit) begin
            rspData <= curReq.write ? '0 : loadData;
            rspHit  <= !missed;                 // Replayed lookup reports a miss
        end else if ((state == MMIO) && memDoneQ) begin
            rspData <= curReq.write ? '0 : memRdata;   // Raw word
            rspHit  <= 1'b0;
        end
    end

endmodule

// File: cacheStore.sv
module cacheStore (
    input  logic             clk,
    input  logic             rst,
    input  cachePkg::index_t index,
    input  cachePkg::tag_t   tag,
    input  logic             fillEn,       // Load victim way from memory
    input  logic             writeEn,      // Store merged word into hit way
    input  logic             lruTouch,     // Load hit
    input  cachePkg::word_t  fillData,
    input  cachePkg::word_t  writeData,
    output logic             hit,
    output cachePkg::way_t   hitWay,
    output cachePkg::word_t  hitData,
    output logic             victimDirty,
    output cachePkg::tag_t   victimTag,
    output cachePkg::word_t  victimData
);
    import cachePkg::*;

    tag_t  tagArr   [NumSets][NumWays];
    word_t dataArr  [NumSets][NumWays];
    logic  validArr [NumSets][NumWays];
    logic  dirtyArr [NumSets][NumWays];
    way_t  lruArr   [NumSets];          // Points at the least recently used way

    way_t  victimWay;

    // Both ways compared in parallel
    always_comb begin
        hit    = 1'b0;
        hitWay = '0;
        for (int w = 0; w < NumWays; w++) begin
            if (validArr[index][w] && (tagArr[index][w] == tag)) begin
                hit    = 1'b1;
                hitWay = way_t'(w);
            end
        end
    end

    assign hitData = dataArr[index][hitWay];

    // Replacement candidate
    assign victimWay   = lruArr[index];
    assign victimDirty = validArr[index][victimWay] && dirtyArr[index][victimWay];
    assign victimTag   = tagArr[index][victimWay];
    assign victimData  = dataArr[index][victimWay];

    // Status bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NumSets; s++) begin
                lruArr[s] <= '0;
                for (int w = 0; w < NumWays; w++) begin
                    validArr[s][w] <= 1'b0;
                    dirtyArr[s][w] <= 1'b0;
                end
            end
        end else begin
            if (fillEn) begin
                validArr[index][victimWay] <= 1'b1;
                dirtyArr[index][victimWay] <= 1'b0;   // Fresh copy of memory
                lruArr[index]              <= ~victimWay;
            end
            if (writeEn) begin
                dirtyArr[index][hitWay] <= 1'b1;
                lruArr[index]           <= ~hitWay;
            end
            if (lruTouch) begin
                lruArr[index] <= ~hitWay;
            end
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (fillEn) begin
            tagArr[index][victimWay]  <= tag;
            dataArr[index][victimWay] <= fillData;
        end
        if (writeEn) begin
            dataArr[index][hitWay] <= writeData;
        end
    end

endmodule

// File: loadStoreAlign.sv
module loadStoreAlign (
    input  memBusPkg::accessSize_e size,
    input  logic [1:0]             byteOffset,
    input  cachePkg::word_t        lineWord,     // Word of the hit way
    input  cachePkg::word_t        storeData,
    output cachePkg::word_t        mergedWord,
    output cachePkg::word_t        loadData
);
    import cachePkg::*;
    import memBusPkg::*;

    logic [4:0] byteShift;   // Bit position of the addressed byte
    logic [4:0] halfShift;   // Bit position of the addressed halfword
    word_t      shifted;     // Addressed lanes moved to the bottom

    // Halfwords ignore bit 0, misaligned is taken as aligned
    assign byteShift = {byteOffset, 3'b000};
    assign halfShift = {byteOffset[1], 4'b0000};

    // Load path
    always_comb begin
        shifted = '0;
        case (size)
            LB, LBU: shifted = lineWord >> byteShift;
            LH, LHU: shifted = lineWord >> halfShift;
            default: shifted = lineWord;
        endcase

        case (size)
            LB:      loadData = {{24{shifted[7]}}, shifted[7:0]};    // Sign extend byte
            LH:      loadData = {{16{shifted[15]}}, shifted[15:0]};  // Sign extend half
            LW:      loadData = shifted;
            LBU:     loadData = {24'b0, shifted[7:0]};
            LHU:     loadData = {16'b0, shifted[15:0]};
            default: loadData = '0;                                  // Unknown size
        endcase
    end

    // Store path, only the addressed lanes change
    always_comb begin
        mergedWord = lineWord;
        case (size)
            LB:      mergedWord[byteShift +: 8]  = storeData[7:0];   // sb
            LH:      mergedWord[halfShift +: 16] = storeData[15:0];  // sh
            LW:      mergedWord = storeData;                         // sw
            default: mergedWord = lineWord;
        endcase
    end

endmodule

// File: memBusPkg.sv
package memBusPkg;

    // Load/store width, RISC-V funct3 encoding
    // Stores use the first three codes
    typedef enum logic [2:0] {
        LB  = 3'b000,   // Also sb
        LH  = 3'b001,   // Also sh
        LW  = 3'b010,   // Also sw
        LBU = 3'b100,
        LHU = 3'b101
    } accessSize_e;

    // Word index into the backing RAM
    typedef logic [$clog2(cachePkg::MemWords)-1:0] memAddr_t;

    // CPU request, 68 bits
    typedef struct packed {
        logic                  write;   // 1 for stores
        accessSize_e           size;
        cachePkg::addr_t       addr;    // Byte address
        cachePkg::word_t       wdata;   // Store data, low lanes
    } cpuReq_t;

    // CPU response, 33 bits
    typedef struct packed {
        cachePkg::word_t       rdata;   // Extended load data
        logic                  hit;     // Served without memory
    } cpuRsp_t;

    // Backing memory request, 41 bits
    typedef struct packed {
        logic                  write;
        memAddr_t              wordAddr;
        cachePkg::word_t       wdata;
    } memReq_t;

endpackage

// File: cachePkg.sv
package cachePkg;

    // Cache geometry
    localparam int NumSets    = 4;
    localparam int NumWays    = 2;
    localparam int TagWidth   = 28;   // Address bits 31 to 4
    localparam int IndexWidth = 2;    // Address bits 3 to 2

    // Backing memory
    localparam int MemLatency = 3;    // Cycles from start to done
    localparam int MemWords   = 256;

    typedef logic [31:0]               word_t;
    typedef logic [31:0]               addr_t;
    typedef logic [TagWidth-1:0]       tag_t;
    typedef logic [IndexWidth-1:0]     index_t;
    typedef logic [$clog2(NumWays)-1:0] way_t;

    // Uncached word, bypasses the arrays
    localparam addr_t MmioAddr = 32'h0000_00FC;

endpackage
